// ==== Makefile ====
# Verilator build, run, lint and clean

TB_TOP := tb_fc_subsystem

.PHONY: all lint clean

all:
	verilator --binary --timing -f src.f --top-module $(TB_TOP) -o V$(TB_TOP)
	./obj_dir/V$(TB_TOP)

lint:
	verilator --lint-only --timing -f src.f --top-module fc_subsystem

clean:
	rm -rf obj_dir

// ==== fc_bus_pkg.sv ====
`include "fc_defs.svh"

package fc_bus_pkg;

  // ******************************
  // L2 bus payload types
  // ******************************

  // Byte address
  typedef logic [`FC_AW-1:0] addr_t;

  // Read and write data word
  typedef logic [`FC_DW-1:0] data_t;

  // One enable per byte lane
  typedef logic [`FC_DW/8-1:0] be_t;

endpackage

// ==== fc_core.sv ====
`include "fc_defs.svh"

module fc_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_en_i,
  input  fc_bus_pkg::addr_t    boot_addr_i,
  input  logic                 debug_req_i,
  // Instruction strobe and response
  output logic                 instr_req_o,
  output fc_bus_pkg::addr_t    instr_addr_o,
  input  logic                 instr_rvalid_i,
  input  fc_bus_pkg::data_t    instr_rdata_i,
  input  logic                 instr_err_i,
  // Data strobe and response
  output logic                 data_req_o,
  output fc_bus_pkg::addr_t    data_addr_o,
  output logic                 data_we_o,
  output fc_bus_pkg::data_t    data_wdata_o,
  output fc_bus_pkg::be_t      data_be_o,
  input  logic                 data_rvalid_i,
  input  fc_bus_pkg::data_t    data_rdata_i,
  input  logic                 data_err_i,
  // Interrupt latch
  input  logic                 irq_pending_i,
  input  fc_core_pkg::irq_id_t irq_id_i,
  output logic                 irq_ack_o,
  output fc_core_pkg::irq_id_t irq_ack_id_o,
  output logic                 halted_o
);

  import fc_bus_pkg::*;
  import fc_core_pkg::*;

  core_state_e state_q, state_d;
  addr_t       pc_q, pc_d;
  data_t       acc_q, acc_d;
  data_t       ir_q;
  logic        instr_req_q, instr_req_d;
  logic        data_req_q, data_req_d;
  logic        ack_q, ack_d;
  irq_id_t     ack_id_q;
  logic        dbg_q;
  logic        halt_req;

  // Decoded fields of the current instruction
  opcode_e                opcode;
  logic [`FC_IMM_W-1:0]   imm;
  addr_t                  imm_addr;

  assign opcode   = opcode_e'(ir_q[`FC_OPC_MSB:`FC_OPC_LSB]);
  assign imm      = ir_q[`FC_IMM_W-1:0];
  assign imm_addr = {{(`FC_AW-`FC_IMM_W){1'b0}}, imm};

  // Debug request stays armed until the core stops
  assign halt_req = debug_req_i | dbg_q;

  // ******************************
  // Sequencer next state
  // ******************************
  always_comb begin
    state_d     = state_q;
    pc_d        = pc_q;
    acc_d       = acc_q;
    instr_req_d = 1'b0;
    data_req_d  = 1'b0;
    ack_d       = 1'b0;
    case (state_q)
      IDLE: begin
        if (halt_req) begin
          state_d = HALTED;
        end else if (fetch_en_i) begin
          pc_d        = boot_addr_i;
          instr_req_d = 1'b1;
          state_d     = FETCH;
        end
      end
      FETCH: begin
        // Wait for the fetched word
        if (instr_rvalid_i) begin
          if (instr_err_i || halt_req) begin
            state_d = HALTED;
          end else begin
            state_d = EXEC;
          end
        end
      end
      EXEC: begin
        if (halt_req) begin
          state_d = HALTED;
        end else begin
          pc_d = pc_q + addr_t'(4);
          case (opcode)
            LDI: begin
              acc_d       = data_t'(imm);
              instr_req_d = 1'b1;
              state_d     = FETCH;
            end
            // Memory operand at the immediate address
            LD, ADD, ST: begin
              data_req_d = 1'b1;
              state_d    = MEM;
            end
            JMP: begin
              pc_d        = imm_addr;
              instr_req_d = 1'b1;
              state_d     = FETCH;
            end
            WFI: begin
              state_d = WAIT_IRQ;
            end
            HALT: begin
              state_d = HALTED;
            end
            default: begin
              instr_req_d = 1'b1;
              state_d     = FETCH;
            end
          endcase
        end
      end
      MEM: begin
        if (data_rvalid_i) begin
          if (data_err_i || halt_req) begin
            state_d = HALTED;
          end else begin
            // Load replaces, add accumulates, store leaves acc alone
            if (opcode == LD) begin
              acc_d = data_rdata_i;
            end else if (opcode == ADD) begin
              acc_d = acc_q + data_rdata_i;
            end
            instr_req_d = 1'b1;
            state_d     = FETCH;
          end
        end
      end
      WAIT_IRQ: begin
        if (halt_req) begin
          state_d = HALTED;
        end else if (irq_pending_i) begin
          // Take the lowest pending id into the accumulator
          ack_d       = 1'b1;
          acc_d       = data_t'(irq_id_i);
          instr_req_d = 1'b1;
          state_d     = FETCH;
        end
      end
      default: begin
        // Stopped for good
        state_d = HALTED;
      end
    endcase
  end

  // ******************************
  // State registers
  // ******************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      pc_q        <= '0;
      acc_q       <= '0;
      instr_req_q <= 1'b0;
      data_req_q  <= 1'b0;
      ack_q       <= 1'b0;
      dbg_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      pc_q        <= pc_d;
      acc_q       <= acc_d;
      instr_req_q <= instr_req_d;
      data_req_q  <= data_req_d;
      ack_q       <= ack_d;
      if (debug_req_i) begin
        dbg_q <= 1'b1;
      end
    end
  end

  // Instruction word and acked id
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH && instr_rvalid_i) begin
      ir_q <= instr_rdata_i;
    end
    if (ack_d) begin
      ack_id_q <= irq_id_i;
    end
  end

  // Strobes are single-cycle pulses on state entry
  assign instr_req_o  = instr_req_q;
  assign instr_addr_o = pc_q;

  assign data_req_o   = data_req_q;
  assign data_addr_o  = imm_addr;
  assign data_we_o    = (opcode == ST);
  assign data_wdata_o = acc_q;
  assign data_be_o    = '1;

  assign irq_ack_o    = ack_q;
  assign irq_ack_id_o = ack_id_q;
  assign halted_o     = (state_q == HALTED);

endmodule

// ==== fc_core_pkg.sv ====
`include "fc_defs.svh"

package fc_core_pkg;

  // ******************************
  // Instruction set
  // ******************************

  // Unlisted encodings execute as no-op
  typedef enum logic [`FC_OPC_MSB-`FC_OPC_LSB:0] {
    LDI  = 4'd1,
    LD   = 4'd2,
    ADD  = 4'd3,
    ST   = 4'd4,
    JMP  = 4'd5,
    WFI  = 4'd6,
    HALT = 4'd7
  } opcode_e;

  // Index of one event line
  typedef logic [$clog2(`FC_N_EVENTS)-1:0] irq_id_t;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    EXEC,
    MEM,
    WAIT_IRQ,
    HALTED
  } core_state_e;

endpackage

// ==== fc_defs.svh ====
`ifndef FC_DEFS_SVH
`define FC_DEFS_SVH

// ******************************
// Bus geometry
// ******************************

// One word of address and data
`define FC_AW 32
`define FC_DW 32

// ******************************
// Instruction word layout
// ******************************

// Opcode nibble at the top of the word
`define FC_OPC_MSB 31
`define FC_OPC_LSB 28
// Immediate or byte address in the low half
`define FC_IMM_W 16

// Event lines into the pending latch
`define FC_N_EVENTS 32

`endif

// ==== fc_irq_latch.sv ====
`include "fc_defs.svh"

module fc_irq_latch (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`FC_N_EVENTS-1:0] events_i,
  input  logic                    ack_i,
  input  fc_core_pkg::irq_id_t    ack_id_i,
  output logic                    pending_o,
  output fc_core_pkg::irq_id_t    pending_id_o
);

  import fc_core_pkg::*;

  logic [`FC_N_EVENTS-1:0] pending_q;
  logic [`FC_N_EVENTS-1:0] pending_d;
  logic [`FC_N_EVENTS-1:0] ack_mask;

  // One-hot mask of the acknowledged line
  always_comb begin
    ack_mask = '0;
    if (ack_i) begin
      ack_mask[ack_id_i] = 1'b1;
    end
  end

  // New event on the acked line keeps the bit set
  assign pending_d = (pending_q & ~ack_mask) | events_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // Lowest set bit wins, scan from the top down
  always_comb begin
    pending_id_o = '0;
    for (int i = `FC_N_EVENTS - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        pending_id_o = irq_id_t'(i);
      end
    end
  end

  assign pending_o = |pending_q;

endmodule

// ==== fc_l2_bridge.sv ====
module fc_l2_bridge (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Core side, one-cycle request strobe
  input  logic              core_req_i,
  input  fc_bus_pkg::addr_t core_addr_i,
  input  logic              core_we_i,
  input  fc_bus_pkg::data_t core_wdata_i,
  input  fc_bus_pkg::be_t   core_be_i,
  output logic              core_rvalid_o,
  output fc_bus_pkg::data_t core_rdata_o,
  output logic              core_err_o,
  // L2 master port
  output logic              l2_req_o,
  output fc_bus_pkg::addr_t l2_addr_o,
  output logic              l2_wen_o,
  output fc_bus_pkg::data_t l2_wdata_o,
  output fc_bus_pkg::be_t   l2_be_o,
  input  logic              l2_gnt_i,
  input  logic              l2_r_valid_i,
  input  fc_bus_pkg::data_t l2_r_rdata_i,
  input  logic              l2_r_opc_i
);

  import fc_bus_pkg::*;

  logic  req_q;
  logic  outst_q;
  logic  rvalid_q;
  logic  err_q;
  addr_t addr_q;
  logic  we_q;
  data_t wdata_q;
  be_t   be_q;
  data_t rdata_q;

  // Handshake events
  logic  granted;
  logic  resp;

  assign granted = req_q & l2_gnt_i;
  assign resp    = outst_q & l2_r_valid_i;

  // ******************************
  // Request and outstanding flags
  // ******************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= 1'b0;
      outst_q  <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      // Request held high until the grant cycle
      if (core_req_i) begin
        req_q <= 1'b1;
      end else if (granted) begin
        req_q <= 1'b0;
      end
      // Single transfer in flight between grant and r_valid
      if (granted) begin
        outst_q <= 1'b1;
      end else if (resp) begin
        outst_q <= 1'b0;
      end
      rvalid_q <= resp;
      err_q    <= resp & l2_r_opc_i;
    end
  end

  // Request fields frozen from strobe to grant
  always_ff @(posedge clk_i) begin
    if (core_req_i) begin
      addr_q  <= core_addr_i;
      we_q    <= core_we_i;
      wdata_q <= core_wdata_i;
      be_q    <= core_be_i;
    end
    if (resp) begin
      rdata_q <= l2_r_rdata_i;
    end
  end

  assign l2_req_o      = req_q;
  assign l2_addr_o     = addr_q;
  // Bus write enable is active low
  assign l2_wen_o      = ~we_q;
  assign l2_wdata_o    = wdata_q;
  assign l2_be_o       = be_q;

  assign core_rvalid_o = rvalid_q;
  assign core_rdata_o  = rdata_q;
  assign core_err_o    = err_q;

endmodule

// ==== fc_subsystem.sv ====
`include "fc_defs.svh"

module fc_subsystem (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_en_i,
  input  fc_bus_pkg::addr_t       boot_addr_i,
  input  logic                    debug_req_i,
  input  logic [`FC_N_EVENTS-1:0] events_i,
  // L2 instruction master
  output logic                    l2_instr_req_o,
  output fc_bus_pkg::addr_t       l2_instr_addr_o,
  output logic                    l2_instr_wen_o,
  output fc_bus_pkg::data_t       l2_instr_wdata_o,
  output fc_bus_pkg::be_t         l2_instr_be_o,
  input  logic                    l2_instr_gnt_i,
  input  logic                    l2_instr_r_valid_i,
  input  fc_bus_pkg::data_t       l2_instr_r_rdata_i,
  input  logic                    l2_instr_r_opc_i,
  // L2 data master
  output logic                    l2_data_req_o,
  output fc_bus_pkg::addr_t       l2_data_addr_o,
  output logic                    l2_data_wen_o,
  output fc_bus_pkg::data_t       l2_data_wdata_o,
  output fc_bus_pkg::be_t         l2_data_be_o,
  input  logic                    l2_data_gnt_i,
  input  logic                    l2_data_r_valid_i,
  input  fc_bus_pkg::data_t       l2_data_r_rdata_i,
  input  logic                    l2_data_r_opc_i,
  // Interrupt acknowledge and stop
  output logic                    core_irq_ack_o,
  output fc_core_pkg::irq_id_t    core_irq_ack_id_o,
  output logic                    stoptimer_o
);

  import fc_bus_pkg::*;
  import fc_core_pkg::*;

  // Core instruction side
  logic    instr_req, instr_rvalid, instr_err;
  addr_t   instr_addr;
  data_t   instr_rdata;

  // Core data side
  logic    data_req, data_we, data_rvalid, data_err;
  addr_t   data_addr;
  data_t   data_wdata, data_rdata;
  be_t     data_be;

  // Pending latch to core
  logic    irq_pending;
  irq_id_t irq_id;

  // ******************************
  // Controller core
  // ******************************
  fc_core u_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_en_i    (fetch_en_i),
    .boot_addr_i   (boot_addr_i),
    .debug_req_i   (debug_req_i),
    .instr_req_o   (instr_req),
    .instr_addr_o  (instr_addr),
    .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i (instr_rdata),
    .instr_err_i   (instr_err),
    .data_req_o    (data_req),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_wdata_o  (data_wdata),
    .data_be_o     (data_be),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .data_err_i    (data_err),
    .irq_pending_i (irq_pending),
    .irq_id_i      (irq_id),
    .irq_ack_o     (core_irq_ack_o),
    .irq_ack_id_o  (core_irq_ack_id_o),
    .halted_o      (stoptimer_o)
  );

  // ******************************
  // L2 bridges
  // ******************************

  // Fetches are reads of full words
  fc_l2_bridge u_instr_bridge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_req_i   (instr_req),
    .core_addr_i  (instr_addr),
    .core_we_i    (1'b0),
    .core_wdata_i ('0),
    .core_be_i    ('1),
    .core_rvalid_o(instr_rvalid),
    .core_rdata_o (instr_rdata),
    .core_err_o   (instr_err),
    .l2_req_o     (l2_instr_req_o),
    .l2_addr_o    (l2_instr_addr_o),
    .l2_wen_o     (l2_instr_wen_o),
    .l2_wdata_o   (l2_instr_wdata_o),
    .l2_be_o      (l2_instr_be_o),
    .l2_gnt_i     (l2_instr_gnt_i),
    .l2_r_valid_i (l2_instr_r_valid_i),
    .l2_r_rdata_i (l2_instr_r_rdata_i),
    .l2_r_opc_i   (l2_instr_r_opc_i)
  );

  fc_l2_bridge u_data_bridge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_req_i   (data_req),
    .core_addr_i  (data_addr),
    .core_we_i    (data_we),
    .core_wdata_i (data_wdata),
    .core_be_i    (data_be),
    .core_rvalid_o(data_rvalid),
    .core_rdata_o (data_rdata),
    .core_err_o   (data_err),
    .l2_req_o     (l2_data_req_o),
    .l2_addr_o    (l2_data_addr_o),
    .l2_wen_o     (l2_data_wen_o),
    .l2_wdata_o   (l2_data_wdata_o),
    .l2_be_o      (l2_data_be_o),
    .l2_gnt_i     (l2_data_gnt_i),
    .l2_r_valid_i (l2_data_r_valid_i),
    .l2_r_rdata_i (l2_data_r_rdata_i),
    .l2_r_opc_i   (l2_data_r_opc_i)
  );

  // Sticky event bits, cleared by the core's ack
  fc_irq_latch u_irq_latch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .events_i    (events_i),
    .ack_i       (core_irq_ack_o),
    .ack_id_i    (core_irq_ack_id_o),
    .pending_o   (irq_pending),
    .pending_id_o(irq_id)
  );

endmodule

// ==== src.f ====
+incdir+.
fc_bus_pkg.sv
fc_core_pkg.sv
fc_irq_latch.sv
fc_l2_bridge.sv
fc_core.sv
fc_subsystem.sv
tb_fc_subsystem.sv

// ==== tb_fc_subsystem.sv ====
`include "fc_defs.svh"

module tb_fc_subsystem;

  // Opcode values copied from fc_core_pkg for the program assembler
  localparam logic [3:0] OP_LDI  = 4'd1;
  localparam logic [3:0] OP_LD   = 4'd2;
  localparam logic [3:0] OP_ADD  = 4'd3;
  localparam logic [3:0] OP_ST   = 4'd4;
  localparam logic [3:0] OP_JMP  = 4'd5;
  localparam logic [3:0] OP_WFI  = 4'd6;
  localparam logic [3:0] OP_HALT = 4'd7;

  localparam int          MAX_STEPS = 64;
  localparam logic [31:0] SEED      = 32'h1eb9_872b;

  // L2 model phases
  localparam int PH_IDLE  = 0;
  localparam int PH_STALL = 1;
  localparam int PH_GRANT = 2;
  localparam int PH_RWAIT = 3;
  localparam int PH_RESP  = 4;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    fetch_en_i;
  logic                    debug_req_i;
  logic [31:0]             boot_addr_i;
  logic [`FC_N_EVENTS-1:0] events_i;

  // Port 0 is the instruction master and port 1 the data master
  logic        req_s   [2];
  logic [31:0] addr_s  [2];
  logic        wen_s   [2];
  logic [31:0] wdata_s [2];
  logic [3:0]  be_s    [2];
  logic        gnt     [2];
  logic        rvalid  [2];
  logic [31:0] rdata   [2];
  logic        opc     [2];
  logic        ack;
  logic [4:0]  ack_id;
  logic        stoptimer;

  // Shared word memory and the reference copy
  logic [31:0] mem     [logic [31:0]];
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];
  logic [4:0]  exp_ack [$];
  bit          ref_halts;
  int          ref_steps;
  int unsigned checks_done;

  logic [31:0] lfsr [2];
  bit          watch_on;
  time         deadline;
  bit          fetch_seen;
  bit          err_en;
  logic [31:0] err_addr;

  // Model bookkeeping per port
  int          phase      [2];
  int          cnt        [2];
  logic [31:0] hold_addr  [2];
  logic        hold_wen   [2];
  logic [31:0] hold_wdata [2];
  logic [3:0]  hold_be    [2];
  logic        resp_opc   [2];
  logic        nx_gnt     [2];
  logic        nx_rv      [2];
  logic        nx_opc     [2];
  logic [31:0] nx_rdata   [2];

  fc_subsystem UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_en_i        (fetch_en_i),
    .boot_addr_i       (boot_addr_i),
    .debug_req_i       (debug_req_i),
    .events_i          (events_i),
    .l2_instr_req_o    (req_s[0]),
    .l2_instr_addr_o   (addr_s[0]),
    .l2_instr_wen_o    (wen_s[0]),
    .l2_instr_wdata_o  (wdata_s[0]),
    .l2_instr_be_o     (be_s[0]),
    .l2_instr_gnt_i    (gnt[0]),
    .l2_instr_r_valid_i(rvalid[0]),
    .l2_instr_r_rdata_i(rdata[0]),
    .l2_instr_r_opc_i  (opc[0]),
    .l2_data_req_o     (req_s[1]),
    .l2_data_addr_o    (addr_s[1]),
    .l2_data_wen_o     (wen_s[1]),
    .l2_data_wdata_o   (wdata_s[1]),
    .l2_data_be_o      (be_s[1]),
    .l2_data_gnt_i     (gnt[1]),
    .l2_data_r_valid_i (rvalid[1]),
    .l2_data_r_rdata_i (rdata[1]),
    .l2_data_r_opc_i   (opc[1]),
    .core_irq_ack_o    (ack),
    .core_irq_ack_id_o (ack_id),
    .stoptimer_o       (stoptimer)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ******************************
  // Helpers
  // ******************************

  // Fill pattern for unwritten words depends on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5ac3_96e1;
  endfunction

  function automatic logic [31:0] read_mem(input logic [31:0] a);
    if (mem.exists(a)) return mem[a];
    return fill_word(a);
  endfunction

  function automatic logic [31:0] read_ref(input logic [31:0] a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return fill_word(a);
  endfunction

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [15:0] imm);
    return {op, 12'h000, imm};
  endfunction

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // Stall of 0 to 3 cycles with one LFSR step per bit
  function automatic int draw_delay(input int p);
    logic [1:0] d;
    for (int b = 0; b < 2; b++) begin
      lfsr[p] = lfsr_next(lfsr[p]);
      d[b] = lfsr[p][0];
    end
    return int'(d);
  endfunction

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks_done++;
    assert (act === exp) else begin
      $display("** Error at time %0t: %s expected 0x%08h actual 0x%08h",
               $time, name, exp, act);
      stop_failed("value mismatch");
    end
  endtask

  task automatic check_true(input bit cond, input string why);
    checks_done++;
    assert (cond) else stop_failed(why);
  endtask

  // Request must hold still until granted
  task automatic check_hold(input int p);
    check_true(req_s[p], "request dropped before its grant");
    check_true(addr_s[p] == hold_addr[p] && wen_s[p] == hold_wen[p] &&
               wdata_s[p] == hold_wdata[p] && be_s[p] == hold_be[p],
               "request fields changed before the grant");
  endtask

  // ******************************
  // Reference interpreter
  // ******************************
  function automatic void run_reference(input logic [31:0] boot, input logic [31:0] evs);
    logic [31:0] pc;
    logic [31:0] pc_nx;
    logic [31:0] acc;
    logic [31:0] ir;
    logic [31:0] a;
    logic [31:0] pend;
    logic [4:0]  id;
    bit          done;
    pc = boot;
    acc = '0;
    pend = evs;
    done = 1'b0;
    id = '0;
    ref_halts = 1'b0;
    ref_steps = 0;
    while (!done && ref_steps < MAX_STEPS) begin
      ir = read_ref(pc);
      a = {16'h0000, ir[15:0]};
      pc_nx = pc + 32'd4;
      ref_steps++;
      case (ir[31:28])
        OP_LDI: acc = a;
        OP_LD:  acc = read_ref(a);
        OP_ADD: acc = acc + read_ref(a);
        OP_ST: begin
          ref_mem[a] = acc;
          exp_st_addr.push_back(a);
          exp_st_data.push_back(acc);
        end
        OP_JMP: pc_nx = a;
        OP_WFI: begin
          // Nothing pending means the core waits for good
          if (pend == '0) begin
            done = 1'b1;
          end else begin
            for (int i = 31; i >= 0; i--) begin
              if (pend[i]) id = 5'(i);
            end
            pend[id] = 1'b0;
            exp_ack.push_back(id);
            acc = {27'd0, id};
          end
        end
        OP_HALT: begin
          ref_halts = 1'b1;
          done = 1'b1;
        end
        default: ;
      endcase
      // Error response on a data access stops the core
      if (err_en && a == err_addr && ir[31:28] inside {OP_LD, OP_ADD, OP_ST}) begin
        ref_halts = 1'b1;
        done = 1'b1;
      end
      pc = pc_nx;
    end
  endfunction

  // ******************************
  // L2 memory model, both ports
  // ******************************
  initial begin
    for (int p = 0; p < 2; p++) begin
      phase[p] = PH_IDLE;
      cnt[p] = 0;
      gnt[p] = 1'b0;
      rvalid[p] = 1'b0;
      rdata[p] = '0;
      opc[p] = 1'b0;
      lfsr[p] = SEED;
    end
    forever begin
      @(posedge clk_i);
      for (int p = 0; p < 2; p++) begin
        nx_gnt[p] = 1'b0;
        nx_rv[p] = 1'b0;
        nx_opc[p] = 1'b0;
        nx_rdata[p] = rdata[p];
        case (phase[p])
          PH_IDLE: begin
            if (rst_ni && req_s[p]) begin
              hold_addr[p] = addr_s[p];
              hold_wen[p] = wen_s[p];
              hold_wdata[p] = wdata_s[p];
              hold_be[p] = be_s[p];
              if (p == 0) begin
                // Fetches are full-word reads
                check_value("l2_instr_wen_o", 32'd1, {31'd0, wen_s[0]});
                check_value("l2_instr_be_o", 32'hf, {28'd0, be_s[0]});
                if (!fetch_seen) check_value("l2_instr_addr_o", boot_addr_i, addr_s[0]);
                fetch_seen = 1'b1;
              end
              cnt[p] = draw_delay(p);
              if (cnt[p] == 0) begin
                nx_gnt[p] = 1'b1;
                phase[p] = PH_GRANT;
              end else begin
                phase[p] = PH_STALL;
              end
            end
          end
          PH_STALL: begin
            check_hold(p);
            cnt[p]--;
            if (cnt[p] == 0) begin
              nx_gnt[p] = 1'b1;
              phase[p] = PH_GRANT;
            end
          end
          PH_GRANT: begin
            // Transfer happens at this edge
            check_hold(p);
            if (!hold_wen[p]) mem[hold_addr[p]] = hold_wdata[p];
            nx_rdata[p] = read_mem(hold_addr[p]);
            resp_opc[p] = (p == 1) && err_en && hold_addr[p] == err_addr;
            cnt[p] = draw_delay(p);
            if (cnt[p] == 0) begin
              nx_rv[p] = 1'b1;
              nx_opc[p] = resp_opc[p];
              phase[p] = PH_RESP;
            end else begin
              phase[p] = PH_RWAIT;
            end
          end
          PH_RWAIT: begin
            check_true(!req_s[p], "second request while a transfer is outstanding");
            cnt[p]--;
            if (cnt[p] == 0) begin
              nx_rv[p] = 1'b1;
              nx_opc[p] = resp_opc[p];
              phase[p] = PH_RESP;
            end
          end
          default: begin
            check_true(!req_s[p], "second request while a transfer is outstanding");
            phase[p] = PH_IDLE;
          end
        endcase
      end
      #1;
      for (int p = 0; p < 2; p++) begin
        gnt[p] = nx_gnt[p];
        rvalid[p] = nx_rv[p];
        opc[p] = nx_opc[p];
        rdata[p] = nx_rdata[p];
      end
    end
  end

  // ******************************
  // Comparator
  // ******************************
  always @(posedge clk_i) begin
    // Granted data writes against the expected stores
    if (rst_ni && req_s[1] && gnt[1] && !wen_s[1]) begin
      if (exp_st_addr.size() == 0) begin
        stop_failed("data write made where no store was expected");
      end else begin
        check_value("l2_data_addr_o", exp_st_addr.pop_front(), addr_s[1]);
        check_value("l2_data_wdata_o", exp_st_data.pop_front(), wdata_s[1]);
        check_value("l2_data_be_o", 32'hf, {28'd0, be_s[1]});
      end
    end
    if (rst_ni && ack) begin
      if (exp_ack.size() == 0) begin
        stop_failed("interrupt acknowledged where none was expected");
      end else begin
        check_value("core_irq_ack_id_o", {27'd0, exp_ack.pop_front()}, {27'd0, ack_id});
      end
    end
  end

  // Watchdog armed only while a program runs
  initial begin
    forever begin
      @(posedge clk_i);
      if (watch_on && $time > deadline) begin
        stop_failed("watchdog expired, the DUT did not stop in time");
      end
    end
  end

  // ******************************
  // Run sequence
  // ******************************
  task automatic pulse_event(input int line);
    #1 events_i[line] = 1'b1;
    @(posedge clk_i);
    #1 events_i[line] = 1'b0;
    @(posedge clk_i);
  endtask

  task automatic do_run(input logic [31:0] boot, input logic [31:0] evs,
                        input logic [31:0] evs_again, input bit use_debug);
    #1 rst_ni = 1'b0;
    fetch_en_i = 1'b0;
    debug_req_i = 1'b0;
    events_i = '0;
    boot_addr_i = boot;
    fetch_seen = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    check_value("l2_instr_req_o", 32'd0, {31'd0, req_s[0]});
    check_value("l2_data_req_o", 32'd0, {31'd0, req_s[1]});
    check_value("core_irq_ack_o", 32'd0, {31'd0, ack});
    check_value("stoptimer_o", 32'd0, {31'd0, stoptimer});
    // Idle core makes no fetch
    repeat (8) begin
      @(posedge clk_i);
      check_true(!req_s[0] && !req_s[1], "request made while fetch_en_i was low");
    end
    for (int i = 0; i < `FC_N_EVENTS; i++) begin
      if (evs[i]) pulse_event(i);
    end
    for (int i = 0; i < `FC_N_EVENTS; i++) begin
      if (evs_again[i]) pulse_event(i);
    end
    ref_mem = mem;
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_ack.delete();
    run_reference(boot, evs | evs_again);
    if (!use_debug) check_true(ref_halts, "program under test never stops");
    deadline = $time + 64'(ref_steps) * 64 * 20 * 8 + 800;
    watch_on = 1'b1;
    #1 fetch_en_i = 1'b1;
    if (use_debug) begin
      repeat (40) @(posedge clk_i);
      #1 debug_req_i = 1'b1;
    end
    while (!stoptimer) @(posedge clk_i);
    // Stopped core stays quiet
    repeat (24) begin
      @(posedge clk_i);
      check_true(stoptimer, "stoptimer_o fell after the core stopped");
      check_true(!req_s[0] && !req_s[1], "request made after the core stopped");
    end
    check_true(exp_st_addr.size() == 0 && exp_ack.size() == 0,
               "expected stores or acknowledges did not occur");
    watch_on = 1'b0;
  endtask

  initial begin
    rst_ni = 1'b0;
    fetch_en_i = 1'b0;
    debug_req_i = 1'b0;
    events_i = '0;
    boot_addr_i = '0;
    err_en = 1'b0;
    err_addr = '0;
    watch_on = 1'b0;
    deadline = 0;
    fetch_seen = 1'b0;
    checks_done = 0;

    // Arithmetic, memory and jump
    mem[32'h0100] = 32'h0000_1234;
    mem[32'h0104] = 32'hffff_fff0;
    mem[32'h1000] = encode(OP_LDI, 16'h0042);
    mem[32'h1004] = encode(OP_LD, 16'h0100);
    mem[32'h1008] = encode(OP_ADD, 16'h0104);
    mem[32'h100c] = encode(OP_ST, 16'h0200);
    mem[32'h1010] = encode(OP_LDI, 16'h0007);
    mem[32'h1014] = encode(OP_ADD, 16'h0200);
    mem[32'h1018] = encode(OP_ST, 16'h0204);
    mem[32'h101c] = encode(OP_JMP, 16'h1024);
    mem[32'h1020] = encode(OP_ST, 16'h0300);
    mem[32'h1024] = encode(OP_ADD, 16'h0300);
    mem[32'h1028] = encode(OP_ST, 16'h0208);
    mem[32'h102c] = encode(4'd0, 16'h0000);
    mem[32'h1030] = encode(OP_HALT, 16'h0000);
    do_run(32'h0000_1000, 32'd0, 32'd0, 1'b0);

    // Interrupts with line 7 pulsed twice while pending
    mem.delete();
    mem[32'h2000] = encode(OP_WFI, 16'h0000);
    mem[32'h2004] = encode(OP_ST, 16'h0100);
    mem[32'h2008] = encode(OP_WFI, 16'h0000);
    mem[32'h200c] = encode(OP_ST, 16'h0104);
    mem[32'h2010] = encode(OP_WFI, 16'h0000);
    mem[32'h2014] = encode(OP_ST, 16'h0108);
    mem[32'h2018] = encode(OP_HALT, 16'h0000);
    do_run(32'h0000_2000, 32'h0010_0088, 32'h0000_0080, 1'b0);

    // Endless loop stopped by debug request
    mem.delete();
    mem[32'h3000] = encode(OP_LDI, 16'h0001);
    mem[32'h3004] = encode(OP_ADD, 16'h0100);
    mem[32'h3008] = encode(OP_JMP, 16'h3000);
    do_run(32'h0000_3000, 32'd0, 32'd0, 1'b1);

    // Bus error on the first store
    mem.delete();
    err_en = 1'b1;
    err_addr = 32'h0000_0200;
    mem[32'h4000] = encode(OP_LDI, 16'h0005);
    mem[32'h4004] = encode(OP_ST, 16'h0200);
    mem[32'h4008] = encode(OP_ST, 16'h0204);
    mem[32'h400c] = encode(OP_HALT, 16'h0000);
    do_run(32'h0000_4000, 32'd0, 32'd0, 1'b0);

    if (checks_done > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_failed("no checks were made");
    end
  end

endmodule
